//--- common/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// major opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101

`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010

// alu group, shared by op and op-imm
`define F3_ADD      3'b000  // add/sub, addi
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL      3'b101  // srl/sra
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

//--- common/id_pkg.sv
`include "id_macros.svh"

package id_pkg;

    // one instruction word, six ways to read it
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [4:0]             rs2;
            logic [4:0]             rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } r_fmt;
        struct packed {
            logic [11:0]            imm;
            logic [4:0]             rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } i_fmt;
        struct packed {
            logic [6:0]             imm_hi;
            logic [4:0]             rs2;
            logic [4:0]             rs1;
            logic [2:0]             funct3;
            logic [4:0]             imm_lo;
            logic [6:0]             opcode;
        } s_fmt;
        struct packed {
            logic                   imm12;
            logic [5:0]             imm10_5;
            logic [4:0]             rs2;
            logic [4:0]             rs1;
            logic [2:0]             funct3;
            logic [3:0]             imm4_1;
            logic                   imm11;
            logic [6:0]             opcode;
        } b_fmt;
        struct packed {
            logic [19:0]            imm;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } u_fmt;
        struct packed {
            logic                   imm20;
            logic [9:0]             imm10_1;
            logic                   imm11;
            logic [7:0]             imm19_12;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } j_fmt;
    } inst_u;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_CMP,
        SEL_OTHER, SEL_JB, SEL_LOAD, SEL_STORE
    } alu_sel_e;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } fwd_t;

    typedef struct packed {
        alu_op_e                aluop;
        alu_sel_e               alusel;
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   is_jump;    // jal / jalr
        logic [2:0]             br_f3;
    } id_ctrl_t;

    typedef struct packed {
        alu_op_e                aluop;
        alu_sel_e               alusel;
        logic [`XLEN-1:0]       reg1;
        logic [`XLEN-1:0]       reg2;
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wd;
        logic [`XLEN-1:0]       link_addr;
        logic [`XLEN-1:0]       ls_offset;
    } id_ex_t;

endpackage

//--- decode/inst_decoder.sv
`include "id_macros.svh"

module inst_decoder (
    input  logic                    rst_n_i,
    input  logic [`XLEN-1:0]        pc_i,       // pc + 4
    input  id_pkg::inst_u           inst_i,
    output id_pkg::id_ctrl_t        ctrl_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic [`XLEN-1:0]        link_addr_o,
    output logic [`XLEN-1:0]        ls_offset_o,
    output logic                    rd1_en_o,
    output logic                    rd2_en_o,
    output logic [`REG_ADDR_W-1:0]  rd1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rd2_addr_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               alt;        // bit 30, sub / sra
    logic               is_reg_op;
    logic [`XLEN-1:0]   i_imm;
    logic [`XLEN-1:0]   s_imm;
    logic [`XLEN-1:0]   u_imm;
    logic [`XLEN-1:0]   shamt;

    assign opcode    = inst_i.r_fmt.opcode;
    assign funct3    = inst_i.r_fmt.funct3;
    assign alt       = inst_i.r_fmt.funct7[5];
    assign is_reg_op = (opcode == `OPC_OP);

    assign i_imm = {{(`XLEN-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign s_imm = {{(`XLEN-12){inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi,
                    inst_i.s_fmt.imm_lo};
    assign u_imm = {inst_i.u_fmt.imm, 12'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, inst_i.i_fmt.imm[4:0]};

    always_comb begin
        ctrl_o      = '0;       // nop, no write
        imm_o       = '0;
        link_addr_o = '0;
        ls_offset_o = '0;
        rd1_en_o    = 1'b0;
        rd2_en_o    = 1'b0;
        rd1_addr_o  = inst_i.r_fmt.rs1;
        rd2_addr_o  = inst_i.r_fmt.rs2;
        if (!rst_n_i) begin
            rd1_addr_o = '0;
            rd2_addr_o = '0;
        end else begin
            case (opcode)
                `OPC_LUI, `OPC_AUIPC: begin
                    ctrl_o.aluop  = (opcode == `OPC_LUI) ? id_pkg::ALU_LUI : id_pkg::ALU_AUIPC;
                    ctrl_o.alusel = id_pkg::SEL_OTHER;
                    ctrl_o.wreg   = 1'b1;
                    imm_o         = (opcode == `OPC_LUI) ? u_imm : u_imm + pc_i - 32'd4;
                end
                `OPC_JAL, `OPC_JALR: begin
                    ctrl_o.aluop   = (opcode == `OPC_JAL) ? id_pkg::ALU_JAL : id_pkg::ALU_JALR;
                    ctrl_o.alusel  = id_pkg::SEL_JB;
                    ctrl_o.wreg    = 1'b1;
                    ctrl_o.is_jump = 1'b1;
                    rd1_en_o       = (opcode == `OPC_JALR);  // base register
                    link_addr_o    = pc_i;
                end
                `OPC_BRANCH: begin
                    ctrl_o.alusel = id_pkg::SEL_JB;
                    ctrl_o.br_f3  = funct3;
                    rd1_en_o      = 1'b1;
                    rd2_en_o      = 1'b1;
                    case (funct3)
                        `F3_BEQ:  ctrl_o.aluop = id_pkg::ALU_BEQ;
                        `F3_BNE:  ctrl_o.aluop = id_pkg::ALU_BNE;
                        `F3_BLT:  ctrl_o.aluop = id_pkg::ALU_BLT;
                        `F3_BGE:  ctrl_o.aluop = id_pkg::ALU_BGE;
                        `F3_BLTU: ctrl_o.aluop = id_pkg::ALU_BLTU;
                        `F3_BGEU: ctrl_o.aluop = id_pkg::ALU_BGEU;
                        default:  ctrl_o.aluop = id_pkg::ALU_NOP;
                    endcase
                end
                `OPC_LOAD: begin
                    ctrl_o.alusel = id_pkg::SEL_LOAD;
                    ctrl_o.wreg   = 1'b1;
                    rd1_en_o      = 1'b1;
                    ls_offset_o   = i_imm;
                    case (funct3)
                        `F3_LB:  ctrl_o.aluop = id_pkg::ALU_LB;
                        `F3_LH:  ctrl_o.aluop = id_pkg::ALU_LH;
                        `F3_LW:  ctrl_o.aluop = id_pkg::ALU_LW;
                        `F3_LBU: ctrl_o.aluop = id_pkg::ALU_LBU;
                        `F3_LHU: ctrl_o.aluop = id_pkg::ALU_LHU;
                        default: ctrl_o.aluop = id_pkg::ALU_NOP;
                    endcase
                end
                `OPC_STORE: begin
                    ctrl_o.alusel = id_pkg::SEL_STORE;
                    rd1_en_o      = 1'b1;
                    rd2_en_o      = 1'b1;
                    ls_offset_o   = s_imm;
                    case (funct3)
                        `F3_SB:  ctrl_o.aluop = id_pkg::ALU_SB;
                        `F3_SH:  ctrl_o.aluop = id_pkg::ALU_SH;
                        `F3_SW:  ctrl_o.aluop = id_pkg::ALU_SW;
                        default: ctrl_o.aluop = id_pkg::ALU_NOP;
                    endcase
                end
                `OPC_OP_IMM, `OPC_OP: begin
                    ctrl_o.wreg   = 1'b1;
                    rd1_en_o      = 1'b1;
                    rd2_en_o      = is_reg_op;
                    imm_o         = is_reg_op ? '0 : i_imm;
                    ctrl_o.alusel = id_pkg::SEL_LOGIC;
                    case (funct3)
                        `F3_ADD: ctrl_o.aluop = (alt && is_reg_op) ? id_pkg::ALU_SUB
                                                                   : id_pkg::ALU_ADD;
                        `F3_XOR: ctrl_o.aluop = id_pkg::ALU_XOR;
                        `F3_OR:  ctrl_o.aluop = id_pkg::ALU_OR;
                        `F3_AND: ctrl_o.aluop = id_pkg::ALU_AND;
                        `F3_SLT, `F3_SLTU: begin
                            ctrl_o.aluop  = (funct3 == `F3_SLT) ? id_pkg::ALU_SLT
                                                                : id_pkg::ALU_SLTU;
                            ctrl_o.alusel = id_pkg::SEL_CMP;
                        end
                        `F3_SLL, `F3_SRL: begin
                            if (funct3 == `F3_SLL) begin
                                ctrl_o.aluop = id_pkg::ALU_SLL;
                            end else begin
                                ctrl_o.aluop = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                            end
                            ctrl_o.alusel = id_pkg::SEL_SHIFT;
                            imm_o         = is_reg_op ? '0 : shamt;
                        end
                        default: ctrl_o.aluop = id_pkg::ALU_NOP;
                    endcase
                end
                default: ;
            endcase
            // bad funct3 falls back to a plain nop
            if (ctrl_o.aluop == id_pkg::ALU_NOP) begin
                ctrl_o      = '0;
                imm_o       = '0;
                link_addr_o = '0;
                ls_offset_o = '0;
                rd1_en_o    = 1'b0;
                rd2_en_o    = 1'b0;
            end
            ctrl_o.wd = ctrl_o.wreg ? inst_i.r_fmt.rd : '0;
        end
    end

endmodule

//--- decode/operand_forward.sv
`include "id_macros.svh"

module operand_forward (
    input  logic                    rd1_en_i,
    input  logic                    rd2_en_i,
    input  logic [`REG_ADDR_W-1:0]  rd1_addr_i,
    input  logic [`REG_ADDR_W-1:0]  rd2_addr_i,
    input  logic [`XLEN-1:0]        reg1_data_i,
    input  logic [`XLEN-1:0]        reg2_data_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  id_pkg::fwd_t            ex_fwd_i,
    input  id_pkg::fwd_t            mem_fwd_i,
    output logic [`XLEN-1:0]        reg1_o,
    output logic [`XLEN-1:0]        reg2_o
);

    // ex beats mem beats regfile; unread operands take the immediate
    function automatic logic [`XLEN-1:0] pick_operand(
        input logic                   rd_en,
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rf_data,
        input id_pkg::fwd_t           ex,
        input id_pkg::fwd_t           mem,
        input logic [`XLEN-1:0]       imm
    );
        if (!rd_en) begin
            return imm;
        end
        if (ex.we && (ex.addr == addr)) begin   // x0 matches too
            return ex.data;
        end
        if (mem.we && (mem.addr == addr)) begin
            return mem.data;
        end
        return rf_data;
    endfunction

    assign reg1_o = pick_operand(rd1_en_i, rd1_addr_i, reg1_data_i,
                                 ex_fwd_i, mem_fwd_i, imm_i);
    assign reg2_o = pick_operand(rd2_en_i, rd2_addr_i, reg2_data_i,
                                 ex_fwd_i, mem_fwd_i, imm_i);

endmodule

//--- decode/branch_unit.sv
`include "id_macros.svh"

module branch_unit (
    input  logic                rst_n_i,
    input  logic [`XLEN-1:0]    pc_i,       // pc + 4
    input  id_pkg::inst_u       inst_i,
    input  id_pkg::id_ctrl_t    ctrl_i,
    input  logic [`XLEN-1:0]    reg1_i,
    input  logic [`XLEN-1:0]    reg2_i,
    output logic                branch_flag_o,
    output logic [`XLEN-1:0]    branch_addr_o
);

    logic [`XLEN-1:0]   inst_pc;
    logic [`XLEN-1:0]   b_imm;
    logic [`XLEN-1:0]   j_imm;
    logic [`XLEN-1:0]   i_imm;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               taken;

    assign inst_pc = pc_i - 32'd4;
    assign b_imm = {{(`XLEN-12){inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm11,
                    inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
    assign j_imm = {{(`XLEN-20){inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm19_12,
                    inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};
    assign i_imm = {{(`XLEN-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};

    assign eq   = (reg1_i == reg2_i);
    assign lt_s = ($signed(reg1_i) < $signed(reg2_i));
    assign lt_u = (reg1_i < reg2_i);

    always_comb begin
        case (ctrl_i.br_f3)
            `F3_BEQ:  taken = eq;
            `F3_BNE:  taken = !eq;
            `F3_BLT:  taken = lt_s;
            `F3_BGE:  taken = !lt_s;
            `F3_BLTU: taken = lt_u;
            `F3_BGEU: taken = !lt_u;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        branch_flag_o = 1'b0;
        branch_addr_o = '0;
        if (!rst_n_i) begin
            branch_flag_o = 1'b0;
        end else if (ctrl_i.is_jump) begin
            branch_flag_o = 1'b1;
            if (ctrl_i.aluop == id_pkg::ALU_JALR) begin
                branch_addr_o = reg1_i + i_imm;     // bit 0 left as is
            end else begin
                branch_addr_o = inst_pc + j_imm;
            end
        end else if (ctrl_i.alusel == id_pkg::SEL_JB) begin
            branch_flag_o = taken;
            branch_addr_o = taken ? inst_pc + b_imm : pc_i;
        end
    end

endmodule

//--- src/id_ex_reg.sv
`include "id_macros.svh"

module id_ex_reg (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                rdy_i,
    input  id_pkg::id_ctrl_t    ctrl_i,
    input  logic [`XLEN-1:0]    reg1_i,
    input  logic [`XLEN-1:0]    reg2_i,
    input  logic [`XLEN-1:0]    link_addr_i,
    input  logic [`XLEN-1:0]    ls_offset_i,
    output id_pkg::id_ex_t      id_ex_o
);

    id_pkg::id_ex_t stage_d;

    always_comb begin
        stage_d.aluop     = ctrl_i.aluop;
        stage_d.alusel    = ctrl_i.alusel;
        stage_d.reg1      = reg1_i;
        stage_d.reg2      = reg2_i;
        stage_d.wreg      = ctrl_i.wreg;
        stage_d.wd        = ctrl_i.wd;
        stage_d.link_addr = link_addr_i;
        stage_d.ls_offset = ls_offset_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;          // nop, no write
        end else if (rdy_i) begin
            id_ex_o <= stage_d;
        end
    end

endmodule

//--- src/id_stage.sv
`include "id_macros.svh"

module id_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    rdy_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        inst_i,
    input  logic [`XLEN-1:0]        reg1_data_i,
    input  logic [`XLEN-1:0]        reg2_data_i,
    input  id_pkg::fwd_t            ex_fwd_i,
    input  id_pkg::fwd_t            mem_fwd_i,
    output logic                    reg1_read_o,
    output logic                    reg2_read_o,
    output logic [`REG_ADDR_W-1:0]  reg1_addr_o,
    output logic [`REG_ADDR_W-1:0]  reg2_addr_o,
    output logic                    branch_flag_o,
    output logic [`XLEN-1:0]        branch_addr_o,
    output id_pkg::id_ex_t          id_ex_o
);

    id_pkg::id_ctrl_t   ctrl;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   link_addr;
    logic [`XLEN-1:0]   ls_offset;
    logic [`XLEN-1:0]   reg1;
    logic [`XLEN-1:0]   reg2;

    inst_decoder u_decoder (
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .ctrl_o      (ctrl),
        .imm_o       (imm),
        .link_addr_o (link_addr),
        .ls_offset_o (ls_offset),
        .rd1_en_o    (reg1_read_o),
        .rd2_en_o    (reg2_read_o),
        .rd1_addr_o  (reg1_addr_o),
        .rd2_addr_o  (reg2_addr_o)
    );

    operand_forward u_forward (
        .rd1_en_i    (reg1_read_o),
        .rd2_en_i    (reg2_read_o),
        .rd1_addr_i  (reg1_addr_o),
        .rd2_addr_i  (reg2_addr_o),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .imm_i       (imm),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_o      (reg1),
        .reg2_o      (reg2)
    );

    // redirect to fetch, same cycle
    branch_unit u_branch (
        .rst_n_i       (rst_n_i),
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .ctrl_i        (ctrl),
        .reg1_i        (reg1),
        .reg2_i        (reg2),
        .branch_flag_o (branch_flag_o),
        .branch_addr_o (branch_addr_o)
    );

    id_ex_reg u_id_ex (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rdy_i       (rdy_i),
        .ctrl_i      (ctrl),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .link_addr_i (link_addr),
        .ls_offset_i (ls_offset),
        .id_ex_o     (id_ex_o)
    );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period
    end

    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;           // real falling edge for the async reset
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- sim/id_stage_properties.sv
`include "id_macros.svh"

module id_stage_properties (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 rdy_i,
    input logic [`XLEN-1:0]     inst_i,
    input logic                 branch_flag_o,
    input id_pkg::id_ex_t       id_ex_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [6:0] opcode;

    assign opcode = inst_i[6:0];

    reset_clears: assert property (@(posedge clk_i)
        !rst_n_i |-> (!id_ex_o.wreg && !branch_flag_o))
        else $error("id_ex write or redirect active during reset");

    // back-pressure keeps the ID/EX register frozen
    stall_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rdy_i |=> $stable(id_ex_o))
        else $error("id_ex_o changed while rdy_i was low");

    redirect_opcode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        branch_flag_o |-> (opcode == `OPC_JAL || opcode == `OPC_JALR
                           || opcode == `OPC_BRANCH))
        else $error("redirect raised for a non-jump opcode");

endmodule

bind id_stage id_stage_properties u_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rdy_i         (rdy_i),
    .inst_i        (inst_i),
    .branch_flag_o (branch_flag_o),
    .id_ex_o       (id_ex_o)
);

//--- sim/id_stage_tb.sv
`include "id_macros.svh"

module id_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VEC = 64;

    logic                   clk;
    logic                   rst_n;
    logic                   rdy;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       inst;
    logic [`XLEN-1:0]       reg1_data;
    logic [`XLEN-1:0]       reg2_data;
    id_pkg::fwd_t           ex_fwd;
    id_pkg::fwd_t           mem_fwd;
    logic                   reg1_read;
    logic                   reg2_read;
    logic [`REG_ADDR_W-1:0] reg1_addr;
    logic [`REG_ADDR_W-1:0] reg2_addr;
    logic                   branch_flag;
    logic [`XLEN-1:0]       branch_addr;
    id_pkg::id_ex_t         id_ex;

    // vector table
    logic [31:0]    v_inst [MAX_VEC];
    logic [31:0]    v_pc [MAX_VEC];
    logic [31:0]    v_r1 [MAX_VEC];
    logic [31:0]    v_r2 [MAX_VEC];
    logic [37:0]    v_ex [MAX_VEC];
    logic [37:0]    v_mem [MAX_VEC];
    logic           v_rdy [MAX_VEC];
    logic           e_rd1 [MAX_VEC];
    logic           e_rd2 [MAX_VEC];
    logic [4:0]     e_a1 [MAX_VEC];
    logic [4:0]     e_a2 [MAX_VEC];
    logic           e_bf [MAX_VEC];
    logic [31:0]    e_ba [MAX_VEC];
    id_pkg::id_ex_t e_idex [MAX_VEC];

    int     n_vec = 0;
    int     n_checks = 0;
    int     n_errors = 0;
    logic   loaded = 1'b0;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    id_stage UUT (
        .clk_i(clk), .rst_n_i(rst_n), .rdy_i(rdy), .pc_i(pc), .inst_i(inst),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
        .reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .branch_flag_o(branch_flag), .branch_addr_o(branch_addr), .id_ex_o(id_ex)
    );

    task automatic check_val(input logic [159:0] got, input logic [159:0] exp,
                             input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // input line, then expected line; '#' lines are comments
    task automatic load_vectors(output logic ok);
        integer fd;
        integer r;
        string line;
        logic have_in;
        logic [4:0] t_op;
        logic [2:0] t_sel;
        logic [31:0] t_r1;
        logic [31:0] t_r2;
        logic [31:0] t_link;
        logic [31:0] t_ls;
        logic t_wreg;
        logic [4:0] t_wd;
        have_in = 1'b0;
        fd = $fopen("sim/id_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                r = $fgets(line, fd);
                if (r == 0 || line.len() < 4 || line[0] == "#") continue;
                if (!have_in) begin
                    r = $sscanf(line, "%h %h %h %h %h %h %h", v_inst[n_vec], v_pc[n_vec],
                                v_r1[n_vec], v_r2[n_vec], v_ex[n_vec], v_mem[n_vec],
                                v_rdy[n_vec]);
                    have_in = 1'b1;
                end else begin
                    r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                e_rd1[n_vec], e_rd2[n_vec], e_a1[n_vec], e_a2[n_vec],
                                e_bf[n_vec], e_ba[n_vec], t_op, t_sel, t_r1, t_r2,
                                t_wreg, t_wd, t_link, t_ls);
                    e_idex[n_vec].aluop     = id_pkg::alu_op_e'(t_op);
                    e_idex[n_vec].alusel    = id_pkg::alu_sel_e'(t_sel);
                    e_idex[n_vec].reg1      = t_r1;
                    e_idex[n_vec].reg2      = t_r2;
                    e_idex[n_vec].wreg      = t_wreg;
                    e_idex[n_vec].wd        = t_wd;
                    e_idex[n_vec].link_addr = t_link;
                    e_idex[n_vec].ls_offset = t_ls;
                    n_vec++;
                    have_in = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vec(input int k);
        inst      <= v_inst[k];
        pc        <= v_pc[k];
        reg1_data <= v_r1[k];
        reg2_data <= v_r2[k];
        ex_fwd    <= v_ex[k];
        mem_fwd   <= v_mem[k];
        rdy       <= v_rdy[k];
    endtask

    task automatic check_comb(input int k);
        check_val(160'(reg1_read), 160'(e_rd1[k]), $sformatf("vec %0d reg1_read", k));
        check_val(160'(reg2_read), 160'(e_rd2[k]), $sformatf("vec %0d reg2_read", k));
        check_val(160'(reg1_addr), 160'(e_a1[k]), $sformatf("vec %0d reg1_addr", k));
        check_val(160'(reg2_addr), 160'(e_a2[k]), $sformatf("vec %0d reg2_addr", k));
        check_val(160'(branch_flag), 160'(e_bf[k]), $sformatf("vec %0d branch_flag", k));
        check_val(160'(branch_addr), 160'(e_ba[k]), $sformatf("vec %0d branch_addr", k));
    endtask

    initial begin : watchdog
        wait (loaded);
        #((n_vec + 16 + 10) * 10);
        $display("run timed out before all vectors were checked");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        logic ok;
        id_pkg::id_ex_t held;
        held      = '0;
        rdy       = 1'b0;          // no capture on the first edge after reset
        pc        = 32'h0000_1004;
        inst      = 32'h0020_8063;  // taken beq, redirect and reads must still stay low
        reg1_data = '0;
        reg2_data = '0;
        ex_fwd    = '0;
        mem_fwd   = '0;
        load_vectors(ok);
        if (!ok || n_vec == 0) begin
            $display("could not read any vectors from sim/id_stimulus.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            @(negedge clk);
            check_val(160'(id_ex), 160'(0), "reset id_ex");
            check_val(160'(branch_flag), 160'(0), "reset branch_flag");
            check_val(160'({reg1_read, reg2_read}), 160'(0), "reset read enables");
            wait (rst_n);
            for (int i = 0; i <= n_vec; i++) begin
                @(posedge clk);
                if (i < n_vec) drive_vec(i);
                @(negedge clk);
                if (i < n_vec) check_comb(i);
                if (i > 0 && v_rdy[i-1]) held = e_idex[i-1];
                check_val(160'(id_ex), 160'(held), $sformatf("vec %0d id_ex", i));
            end
            $display("checks: %0d, errors: %0d", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- sim/id_stimulus.txt
# in : inst pc reg1_data reg2_data ex_fwd{we,addr,data} mem_fwd rdy
# exp: rd1 rd2 a1 a2 bflag baddr aluop alusel reg1 reg2 wreg wd link_addr ls_offset
002081b3 00001004 11111111 22222222 21aaaaaaaa 21bbbbbbbb 1
1 1 01 02 0 00000000 01 1 aaaaaaaa 22222222 1 03 00000000 00000000
40208233 00001004 11111111 22222222 27cccccccc 22dddddddd 1
1 1 01 02 0 00000000 02 1 11111111 dddddddd 1 04 00000000 00000000
fff08293 00001004 11111111 22222222 01eeeeeeee 0000000000 1
1 0 01 1f 0 00000000 01 1 11111111 ffffffff 1 05 00000000 00000000
40315313 00001004 11111111 22222222 0000000000 0000000000 1
1 0 02 03 0 00000000 0a 2 11111111 00000003 1 06 00000000 00000000
0050b393 00001004 11111111 22222222 0000000000 0000000000 1
1 0 01 05 0 00000000 04 3 11111111 00000005 1 07 00000000 00000000
12345437 00001004 11111111 22222222 0000000000 0000000000 1
0 0 08 03 0 00000000 0b 4 12345000 12345000 1 08 00000000 00000000
00001497 00001004 11111111 22222222 0000000000 0000000000 1
0 0 00 00 0 00000000 0c 4 00002000 00002000 1 09 00000000 00000000
ffc0a503 00001004 11111111 22222222 0000000000 0000000000 1
1 0 01 1c 0 00000000 17 6 11111111 00000000 1 0a 00000000 fffffffc
00208423 00001004 11111111 22222222 0000000000 0000000000 1
1 1 01 02 0 00000000 1a 7 11111111 22222222 0 00 00000000 00000008
fe209f23 00001004 11111111 22222222 0000000000 0000000000 1
1 1 01 02 0 00000000 1b 7 11111111 22222222 0 00 00000000 fffffffe
0020c863 00001004 ffffffff 00000001 0000000000 0000000000 1
1 1 01 02 1 00001010 11 5 ffffffff 00000001 0 00 00000000 00000000
0020e863 00001004 ffffffff 00000001 0000000000 0000000000 1
1 1 01 02 0 00001004 13 5 ffffffff 00000001 0 00 00000000 00000000
0020f863 00001004 ffffffff 00000001 0000000000 0000000000 1
1 1 01 02 1 00001010 14 5 ffffffff 00000001 0 00 00000000 00000000
fe208ce3 00002004 00000005 00000005 0000000000 0000000000 1
1 1 01 02 1 00001ff8 0f 5 00000005 00000005 0 00 00000000 00000000
00209863 00001004 00000005 00000005 0000000000 0000000000 1
1 1 01 02 0 00001004 10 5 00000005 00000005 0 00 00000000 00000000
0020d863 00001004 00000001 ffffffff 0000000000 0000000000 1
1 1 01 02 1 00001010 12 5 00000001 ffffffff 0 00 00000000 00000000
100000ef 00001004 11111111 22222222 0000000000 0000000000 1
0 0 00 00 1 00001100 0d 5 00000000 00000000 1 01 00001004 00000000
003280e7 00001004 11111111 22222222 2500002000 0000000000 1
1 0 05 03 1 00002003 0e 5 00002000 00000000 1 01 00001004 00000000
002081b3 00001004 11111111 22222222 0000000000 0000000000 0
1 1 01 02 0 00000000 01 1 11111111 22222222 1 03 00000000 00000000
00000000 00001004 11111111 22222222 0000000000 0000000000 1
0 0 00 00 0 00000000 00 0 00000000 00000000 0 00 00000000 00000000

//--- id_stage.f
+incdir+common
common/id_pkg.sv
decode/inst_decoder.sv
decode/operand_forward.sv
decode/branch_unit.sv
src/id_ex_reg.sv
src/id_stage.sv
sim/tb_clock_gen.sv
sim/id_stage_properties.sv
sim/id_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb \
    -o id_stage_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/id_stage_sim)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1
